// File: hw/bus_regs.sv
////////////////////////////////////////
// cpu byte bus register file
// even byte latched, odd byte commits the word
// sequences vram accesses and xr writes, holds intr mask
////////////////////////////////////////
`timescale 1ns/1ps

module bus_regs (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                bus_cs_n_i,     // low one cycle per byte
    input  logic                bus_rd_nwr_i,   // 1 read, 0 write
    input  logic [3:0]          bus_reg_num_i,
    input  logic                bus_bytesel_i,  // 0 even/high, 1 odd/low
    input  logic [7:0]          bus_data_i,
    output logic [7:0]          bus_data_o,
    vram_port_if.requester      vram,
    xr_port_if.host             xr,
    input  vc_pkg::intr_t       intr_status_i,
    output vc_pkg::intr_t       intr_mask_o,
    output vc_pkg::intr_t       intr_clear_o    // one cycle strobe
);
    import vc_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE
    } vram_state_t;

    vram_state_t state;         // pending vram access
    logic [7:0]  even_byte;     // high byte waiting for its odd byte
    word_t       xr_addr;
    word_t       vram_addr;
    word_t       wr_word;       // last committed word
    word_t       rd_word;       // prefetched vram word
    word_t       reg_word;      // read mux before byte select
    logic        rd_load;
    logic        bus_wr;
    logic        commit;

    assign bus_wr = !bus_cs_n_i && !bus_rd_nwr_i;
    assign commit = bus_wr && bus_bytesel_i;

    // request fields come straight from held state
    assign vram.sel   = (state != ST_IDLE);
    assign vram.wr    = (state == ST_WRITE);
    assign vram.addr  = vram_addr;
    assign vram.wdata = wr_word;
    assign xr.addr    = xr_addr;
    assign xr.wdata   = wr_word;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state        <= ST_IDLE;
            xr.wr        <= 1'b0;
            xr_addr      <= '0;
            vram_addr    <= '0;
            rd_load      <= 1'b0;
            intr_mask_o  <= '0;
            intr_clear_o <= '0;
        end else begin
            xr.wr        <= 1'b0;
            intr_clear_o <= '0;
            rd_load      <= vram.gnt && !vram.wr;   // data arrives next cycle
            if (xr.wr) begin
                xr_addr <= xr_addr + 1'b1;          // step after the write went out
            end
            case (state)
                ST_WRITE: begin
                    if (vram.gnt) begin
                        vram_addr <= vram_addr + 1'b1;
                        state     <= ST_READ;       // prefetch the next word
                    end
                end
                ST_READ: begin
                    if (vram.gnt) begin
                        state <= ST_IDLE;
                    end
                end
                default: ;
            endcase
            // mask byte acts alone
            if (bus_wr && !bus_bytesel_i && bus_reg_num_i == REG_INTR) begin
                intr_mask_o <= bus_data_i[3:0];
            end
            if (commit) begin
                case (bus_reg_num_i)
                    REG_XR_ADDR: xr_addr <= {even_byte, bus_data_i};
                    REG_XR_DATA: xr.wr <= 1'b1;
                    REG_VRAM_ADDR: begin
                        vram_addr <= {even_byte, bus_data_i};
                        state     <= ST_READ;
                    end
                    REG_VRAM_DATA: state <= ST_WRITE;
                    REG_INTR: intr_clear_o <= bus_data_i[3:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus_wr && !bus_bytesel_i) begin
            even_byte <= bus_data_i;
        end
        if (commit) begin
            wr_word <= {even_byte, bus_data_i};
        end
        if (rd_load) begin
            rd_word <= vram.rdata;
        end
    end

    always_comb begin
        case (bus_reg_num_i)
            REG_XR_ADDR:   reg_word = xr_addr;
            REG_XR_DATA:   reg_word = xr.rdata;
            REG_VRAM_ADDR: reg_word = vram_addr;
            REG_VRAM_DATA: reg_word = rd_word;
            REG_INTR:      reg_word = {4'h0, intr_mask_o, 4'h0, intr_status_i};
            default:       reg_word = '0;
        endcase
    end

    assign bus_data_o = bus_bytesel_i ? reg_word[7:0] : reg_word[15:8];

endmodule

// File: hw/sync_ram.sv
////////////////////////////////////////
// simple dual port block ram
// one write port, registered read port
// word type set per instance
////////////////////////////////////////
`timescale 1ns/1ps

module sync_ram #(
    parameter type word_type = logic [15:0],
    parameter int  ADDR_W    = 8
) (
    input  logic              clk,
    input  logic              wr_en_i,
    input  logic [ADDR_W-1:0] wr_addr_i,
    input  word_type          wr_data_i,
    input  logic              rd_en_i,
    input  logic [ADDR_W-1:0] rd_addr_i,
    output word_type          rd_data_o     // one cycle after rd_en_i, held otherwise
);

    word_type mem [2**ADDR_W];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];    // read before write on a collision
        end
    end

endmodule

// File: hw/vc_pkg.sv
////////////////////////////////////////
// shared constants and types for the video controller
// register numbers, XR map, display timing, memory sizes
// import inside module bodies, scoped names in port lists
////////////////////////////////////////

package vc_pkg;

    typedef logic [15:0] word_t;            // bus, vram and xr word
    typedef logic [11:0] color_t;           // rgb444
    typedef logic [3:0]  intr_t;            // one bit per interrupt source

    // cpu bus register numbers
    localparam logic [3:0] REG_XR_ADDR   = 4'h0;
    localparam logic [3:0] REG_XR_DATA   = 4'h1;
    localparam logic [3:0] REG_VRAM_ADDR = 4'h2;
    localparam logic [3:0] REG_VRAM_DATA = 4'h3;
    localparam logic [3:0] REG_INTR      = 4'h4;

    // xr space, bit 15 picks registers or memory
    localparam word_t XR_VID_CTRL   = 16'h0000;   // border index 11:8, soft intr 3:1
    localparam word_t XR_DISP_START = 16'h0001;   // word address of line 0
    localparam word_t XR_LINE_LEN   = 16'h0002;   // words per line
    localparam word_t XR_COLOR_MEM  = 16'h8000;   // palette, bits 13:12 zero

    // tiny display, sync active high
    localparam int H_VISIBLE = 32;
    localparam int H_FRONT   = 4;
    localparam int H_SYNC    = 4;
    localparam int H_BACK    = 4;
    localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_VISIBLE = 8;
    localparam int V_FRONT   = 1;
    localparam int V_SYNC    = 2;
    localparam int V_BACK    = 1;
    localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
    localparam int COUNT_W   = 11;

    localparam int VGEN_DELAY = 6;          // sync delay through the pixel path

    localparam int VRAM_AW = 12;            // 4096 words
    localparam int PAL_AW  = 4;             // 16 colours

endpackage

// File: hw/video_gen.sv
////////////////////////////////////////
// pixel fetcher with its xr video registers
// one vram word per 4 pixels, fetched a group ahead
// colour index leads the syncs by one cycle for the palette
////////////////////////////////////////
`timescale 1ns/1ps

module video_gen (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        xr_wr_i,
    input  vc_pkg::word_t               xr_addr_i,
    input  vc_pkg::word_t               xr_wdata_i,
    output vc_pkg::word_t               xr_rdata_o,
    output logic                        vram_sel_o,
    output logic [vc_pkg::VRAM_AW-1:0]  vram_addr_o,
    input  vc_pkg::word_t               vram_data_i,
    output logic [3:0]                  color_index_o,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        dv_de_o,
    output vc_pkg::intr_t               intr_signal_o
);
    import vc_pkg::*;

    logic [COUNT_W-1:0]    h_count;
    logic [COUNT_W-1:0]    v_count;
    logic                  hsync;
    logic                  vsync;
    logic                  de;
    logic                  vblank_start;
    word_t                 disp_start;
    word_t                 line_len;
    logic [3:0]            border_index;
    logic [VRAM_AW-1:0]    line_base;       // start of the line being fetched
    logic [VRAM_AW-1:0]    word_addr;
    logic [VRAM_AW-1:0]    next_base;
    word_t                 next_word;       // fetched word waiting for its group
    word_t                 pix_shift;       // msb nibble goes out first
    logic [VGEN_DELAY-1:0] hs_dly;
    logic [VGEN_DELAY-1:0] vs_dly;
    logic [VGEN_DELAY-1:0] de_dly;
    logic                  vid_ctrl_wr;

    video_timing timing_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .h_count_o      (h_count),
        .v_count_o      (v_count),
        .hsync_o        (hsync),
        .vsync_o        (vsync),
        .de_o           (de),
        .vblank_start_o (vblank_start)
    );

    assign vid_ctrl_wr = xr_wr_i && (xr_addr_i == XR_VID_CTRL);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            disp_start   <= '0;
            line_len     <= '0;
            border_index <= '0;
        end else if (xr_wr_i) begin
            case (xr_addr_i)
                XR_VID_CTRL:   border_index <= xr_wdata_i[11:8];
                XR_DISP_START: disp_start <= xr_wdata_i;
                XR_LINE_LEN:   line_len <= xr_wdata_i;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (xr_addr_i)
            XR_VID_CTRL:   xr_rdata_o = {4'h0, border_index, 8'h00};
            XR_DISP_START: xr_rdata_o = disp_start;
            XR_LINE_LEN:   xr_rdata_o = line_len;
            default:       xr_rdata_o = '0;
        endcase
    end

    // last cycle of each group, groups 0-7 of the next line, first one in back porch
    assign vram_sel_o  = (h_count[1:0] == 2'd3) &&
                         (h_count < COUNT_W'(H_VISIBLE - 4) || h_count == COUNT_W'(H_TOTAL - 1));
    assign vram_addr_o = word_addr;
    assign next_base   = (v_count == COUNT_W'(V_TOTAL - 1)) ? disp_start[VRAM_AW-1:0]
                                                            : line_base + line_len[VRAM_AW-1:0];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            line_base <= '0;
            word_addr <= '0;
        end else if (h_count == COUNT_W'(H_VISIBLE)) begin
            line_base <= next_base;     // fetches for this line are done
            word_addr <= next_base;
        end else if (vram_sel_o) begin
            word_addr <= word_addr + 1'b1;
        end
    end

    // word lands a cycle after its fetch, moves to the shifter a group later
    always_ff @(posedge clk) begin
        if (h_count[1:0] == 2'd0) begin
            next_word <= vram_data_i;
            pix_shift <= next_word;
        end else begin
            pix_shift <= pix_shift << 4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hs_dly <= '0;
            vs_dly <= '0;
            de_dly <= '0;
        end else begin
            hs_dly <= {hs_dly[VGEN_DELAY-2:0], hsync};
            vs_dly <= {vs_dly[VGEN_DELAY-2:0], vsync};
            de_dly <= {de_dly[VGEN_DELAY-2:0], de};
        end
    end

    assign hsync_o       = hs_dly[VGEN_DELAY-1];
    assign vsync_o       = vs_dly[VGEN_DELAY-1];
    assign dv_de_o       = de_dly[VGEN_DELAY-1];
    assign color_index_o = de_dly[VGEN_DELAY-2] ? pix_shift[15:12] : border_index;

    // soft bits only while VID_CTRL is being written
    assign intr_signal_o = {vid_ctrl_wr ? xr_wdata_i[3:1] : 3'b000, vblank_start};

endmodule

// File: hw/video_ifs.sv
////////////////////////////////////////
// bundles between the bus registers and the top level
// vram_port_if carries held vram requests and grant
// xr_port_if carries xr write strobes and read-back
////////////////////////////////////////
`timescale 1ns/1ps

interface vram_port_if;
    import vc_pkg::*;

    logic  sel;         // held until gnt
    logic  wr;
    word_t addr;
    word_t wdata;
    logic  gnt;         // access happens this cycle
    word_t rdata;       // valid cycle after a read grant

    modport requester (output sel, wr, addr, wdata, input gnt, rdata);
    modport arbiter (input sel, wr, addr, wdata, output gnt, rdata);
endinterface

interface xr_port_if;
    import vc_pkg::*;

    logic  wr;          // one cycle strobe
    word_t addr;
    word_t wdata;
    word_t rdata;       // combinational read-back at addr

    modport host (output wr, addr, wdata, input rdata);
    modport target (input wr, addr, wdata, output rdata);
endinterface

// File: hw/video_main.sv
////////////////////////////////////////
// video controller top level
// vram arbiter with video first, xr decode, palette
// rgb and syncs registered after the palette read
////////////////////////////////////////
`timescale 1ns/1ps

module video_main (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       bus_cs_n_i,
    input  logic       bus_rd_nwr_i,
    input  logic [3:0] bus_reg_num_i,
    input  logic       bus_bytesel_i,
    input  logic [7:0] bus_data_i,
    output logic [7:0] bus_data_o,
    output logic       bus_intr_o,      // one cycle pulse
    output logic [3:0] red_o,
    output logic [3:0] green_o,
    output logic [3:0] blue_o,
    output logic       hsync_o,
    output logic       vsync_o,
    output logic       dv_de_o
);
    import vc_pkg::*;

    vram_port_if vram_bus ();
    xr_port_if   xr_bus ();

    logic               vgen_sel;
    logic [VRAM_AW-1:0] vgen_addr;
    logic [VRAM_AW-1:0] vram_addr;
    logic               vram_wr;
    logic               vram_rd;
    word_t              vram_rdata;
    logic               vgen_reg_wr;
    logic               pal_wr;
    word_t              vgen_rdata;
    logic [3:0]         color_index;
    color_t             pal_color;
    logic               hsync_1;
    logic               vsync_1;
    logic               dv_de_1;
    intr_t              intr_mask;
    intr_t              intr_clear;
    intr_t              intr_signal;
    intr_t              intr_status;

    // bus only gets cycles video leaves free
    assign vram_bus.gnt   = vram_bus.sel && !vgen_sel;
    assign vram_wr        = vram_bus.gnt && vram_bus.wr;
    assign vram_rd        = vgen_sel || (vram_bus.gnt && !vram_bus.wr);
    assign vram_addr      = vgen_sel ? vgen_addr : vram_bus.addr[VRAM_AW-1:0];
    assign vram_bus.rdata = vram_rdata;     // each owner samples right after its grant

    // one xr writer, registers or palette
    assign vgen_reg_wr  = xr_bus.wr && !xr_bus.addr[15];
    assign pal_wr       = xr_bus.wr && xr_bus.addr[15] &&
                          (xr_bus.addr[13:12] == XR_COLOR_MEM[13:12]);
    assign xr_bus.rdata = xr_bus.addr[15] ? '0 : vgen_rdata;

    bus_regs regs_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_cs_n_i    (bus_cs_n_i),
        .bus_rd_nwr_i  (bus_rd_nwr_i),
        .bus_reg_num_i (bus_reg_num_i),
        .bus_bytesel_i (bus_bytesel_i),
        .bus_data_i    (bus_data_i),
        .bus_data_o    (bus_data_o),
        .vram          (vram_bus),
        .xr            (xr_bus),
        .intr_status_i (intr_status),
        .intr_mask_o   (intr_mask),
        .intr_clear_o  (intr_clear)
    );

    video_gen vgen_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .xr_wr_i       (vgen_reg_wr),
        .xr_addr_i     (xr_bus.addr),
        .xr_wdata_i    (xr_bus.wdata),
        .xr_rdata_o    (vgen_rdata),
        .vram_sel_o    (vgen_sel),
        .vram_addr_o   (vgen_addr),
        .vram_data_i   (vram_rdata),
        .color_index_o (color_index),
        .hsync_o       (hsync_1),
        .vsync_o       (vsync_1),
        .dv_de_o       (dv_de_1),
        .intr_signal_o (intr_signal)
    );

    sync_ram #(.word_type(word_t), .ADDR_W(VRAM_AW)) vram_i (
        .clk       (clk),
        .wr_en_i   (vram_wr),
        .wr_addr_i (vram_addr),
        .wr_data_i (vram_bus.wdata),
        .rd_en_i   (vram_rd),
        .rd_addr_i (vram_addr),
        .rd_data_o (vram_rdata)
    );

    sync_ram #(.word_type(color_t), .ADDR_W(PAL_AW)) palette_i (
        .clk       (clk),
        .wr_en_i   (pal_wr),
        .wr_addr_i (xr_bus.addr[PAL_AW-1:0]),
        .wr_data_i (xr_bus.wdata[11:0]),
        .rd_en_i   (1'b1),
        .rd_addr_i (color_index),
        .rd_data_o (pal_color)     // lines up with dv_de_1
    );

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
            dv_de_o <= 1'b0;
        end else begin
            hsync_o <= hsync_1;
            vsync_o <= vsync_1;
            dv_de_o <= dv_de_1;
        end
    end

    // black outside display enable
    always_ff @(posedge clk) begin
        red_o   <= dv_de_1 ? pal_color[11:8] : 4'h0;
        green_o <= dv_de_1 ? pal_color[7:4] : 4'h0;
        blue_o  <= dv_de_1 ? pal_color[3:0] : 4'h0;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            bus_intr_o  <= 1'b0;
            intr_status <= '0;
        end else begin
            bus_intr_o  <= |(intr_signal & intr_mask & ~intr_status);  // new and enabled only
            intr_status <= (intr_status | intr_signal) & ~intr_clear;
        end
    end

endmodule

// File: hw/video_timing.sv
////////////////////////////////////////
// free running display counters
// decodes syncs, display enable and vblank start
////////////////////////////////////////
`timescale 1ns/1ps

module video_timing (
    input  logic                        clk,
    input  logic                        reset_i,
    output logic [vc_pkg::COUNT_W-1:0]  h_count_o,
    output logic [vc_pkg::COUNT_W-1:0]  v_count_o,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        de_o,
    output logic                        vblank_start_o
);
    import vc_pkg::*;

    logic h_last;
    logic v_last;

    assign h_last = (h_count_o == COUNT_W'(H_TOTAL - 1));
    assign v_last = (v_count_o == COUNT_W'(V_TOTAL - 1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_count_o <= '0;
            v_count_o <= '0;
        end else if (h_last) begin
            h_count_o <= '0;
            v_count_o <= v_last ? '0 : v_count_o + 1'b1;   // line step at wrap
        end else begin
            h_count_o <= h_count_o + 1'b1;
        end
    end

    // visible, front porch, sync, back porch
    assign hsync_o = (h_count_o >= COUNT_W'(H_VISIBLE + H_FRONT)) &&
                     (h_count_o < COUNT_W'(H_VISIBLE + H_FRONT + H_SYNC));
    assign vsync_o = (v_count_o >= COUNT_W'(V_VISIBLE + V_FRONT)) &&
                     (v_count_o < COUNT_W'(V_VISIBLE + V_FRONT + V_SYNC));
    assign de_o    = (h_count_o < COUNT_W'(H_VISIBLE)) && (v_count_o < COUNT_W'(V_VISIBLE));

    // first cycle after the last visible line
    assign vblank_start_o = (h_count_o == '0) && (v_count_o == COUNT_W'(V_VISIBLE));

endmodule

// File: testbench/tb_video_main.sv
////////////////////////////////////////
// testbench for the video controller top level
// table of bus accesses, then random vram and palette,
// pixel and frame monitor, interrupt sequence, watchdog
////////////////////////////////////////
`timescale 1ns/1ps

module tb_video_main;
    import vc_pkg::*;

    localparam int CLK_HALF     = 10;
    localparam int DRIVE_DLY    = 2;         // inputs change just after the edge
    localparam int SAMPLE_DLY   = 10;        // bus_data_o read mid cycle
    localparam int ACCESS_GAP   = 8;         // idle cycles after each byte
    localparam int BYTE_CYCLES  = ACCESS_GAP + 1;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int DISP_BASE    = 'h100;
    localparam int LINE_WORDS   = 9;         // stride wider than the 8 shown words
    localparam int LOAD_WORDS   = V_VISIBLE * LINE_WORDS;
    localparam int PAL_SIZE     = 2**PAL_AW;
    localparam int STEP_COUNT   = 19;
    localparam logic [15:0] LFSR_SEED = 16'd28603;
    localparam logic STEP_WR = 1'b0;
    localparam logic STEP_RD = 1'b1;
    // table, load and up to 12 frames of display and interrupt checks
    localparam int WATCHDOG_CYCLES = STEP_COUNT * 2 * BYTE_CYCLES
                                   + (LOAD_WORDS + PAL_SIZE + 2) * 2 * BYTE_CYCLES
                                   + 12 * FRAME_CYCLES + 1000;

    typedef struct packed {
        logic       kind;
        logic [3:0] reg_num;
        word_t      data;
        word_t      expected;
    } step_t;

    logic       clk = 1'b0;
    logic       reset_i;
    logic       bus_cs_n_i;
    logic       bus_rd_nwr_i;
    logic [3:0] bus_reg_num_i;
    logic       bus_bytesel_i;
    logic [7:0] bus_data_i;
    logic [7:0] bus_data_o;
    logic       bus_intr_o;
    logic [3:0] red_o;
    logic [3:0] green_o;
    logic [3:0] blue_o;
    logic       hsync_o;
    logic       vsync_o;
    logic       dv_de_o;

    step_t       steps [STEP_COUNT];
    word_t       vram_model [2**VRAM_AW];
    color_t      pal_model [PAL_SIZE];
    logic [VRAM_AW-1:0] vram_ptr = '0;       // model copy of VRAM_ADDR
    word_t       xr_ptr = '0;                // model copy of XR_ADDR
    logic [15:0] lfsr_state = LFSR_SEED;
    int          check_count = 0;
    int          error_count = 0;
    int          cycle_count = 0;
    // monitor state
    logic        mon_on = 1'b0;
    logic        load_done = 1'b0;
    logic        pix_armed = 1'b0;
    logic        de_prev = 1'b0;
    logic        hs_prev = 1'b0;
    logic        vs_prev = 1'b0;
    int          px = 0;
    int          py = 0;
    int          hs_len = 0;
    int          vs_len = 0;
    int          pix_frames = 0;
    int          pix_count = 0;
    int          intr_count = 0;
    int          last_intr_cycle = 0;

    video_main dut_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_cs_n_i    (bus_cs_n_i),
        .bus_rd_nwr_i  (bus_rd_nwr_i),
        .bus_reg_num_i (bus_reg_num_i),
        .bus_bytesel_i (bus_bytesel_i),
        .bus_data_i    (bus_data_i),
        .bus_data_o    (bus_data_o),
        .bus_intr_o    (bus_intr_o),
        .red_o         (red_o),
        .green_o       (green_o),
        .blue_o        (blue_o),
        .hsync_o       (hsync_o),
        .vsync_o       (vsync_o),
        .dv_de_o       (dv_de_o)
    );

    always #CLK_HALF clk = ~clk;

    always @(posedge clk) cycle_count <= cycle_count + 1;

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int n, output logic [15:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);     // one step per bit
            value      = {value[14:0], lfsr_state[0]};
        end
    endtask

    // one byte access, cs low for a single cycle
    task automatic bus_access(input logic rd_nwr, input logic [3:0] reg_num,
                              input logic bytesel, input logic [7:0] wdata,
                              output logic [7:0] rdata);
        @(posedge clk);
        #DRIVE_DLY;
        bus_cs_n_i    = 1'b0;
        bus_rd_nwr_i  = rd_nwr;
        bus_reg_num_i = reg_num;
        bus_bytesel_i = bytesel;
        bus_data_i    = wdata;
        #SAMPLE_DLY;
        rdata = bus_data_o;
        @(posedge clk);
        #DRIVE_DLY;
        bus_cs_n_i   = 1'b1;
        bus_rd_nwr_i = 1'b1;
        repeat (ACCESS_GAP - 1) @(posedge clk);
    endtask

    // even byte first, odd byte commits; model follows the register rules
    task automatic bus_write(input logic [3:0] reg_num, input word_t data);
        logic [7:0] dummy_byte;
        bus_access(1'b0, reg_num, 1'b0, data[15:8], dummy_byte);
        bus_access(1'b0, reg_num, 1'b1, data[7:0], dummy_byte);
        case (reg_num)
            REG_XR_ADDR: xr_ptr = data;
            REG_XR_DATA: begin
                if (xr_ptr[15] && xr_ptr[13:12] == 2'b00) begin
                    pal_model[xr_ptr[PAL_AW-1:0]] = data[11:0];
                end
                xr_ptr = xr_ptr + 1'b1;
            end
            REG_VRAM_ADDR: vram_ptr = data[VRAM_AW-1:0];
            REG_VRAM_DATA: begin
                vram_model[vram_ptr] = data;
                vram_ptr = vram_ptr + 1'b1;
            end
            default: ;
        endcase
    endtask

    task automatic bus_read(input logic [3:0] reg_num, output word_t data);
        logic [7:0] hi;
        logic [7:0] lo;
        bus_access(1'b1, reg_num, 1'b0, 8'h00, hi);
        bus_access(1'b1, reg_num, 1'b1, 8'h00, lo);
        data = {hi, lo};
    endtask

    // word disp_start + y*line_len + x/4, msb nibble first, through the palette
    function automatic color_t expected_pixel(input int x, input int y);
        logic [VRAM_AW-1:0] addr;
        word_t              w;
        logic [3:0]         nib;
        addr = VRAM_AW'(DISP_BASE + y * LINE_WORDS + x / 4);
        w    = vram_model[addr];
        nib  = w[15 - 4 * (x % 4) -: 4];
        return pal_model[nib];
    endfunction

    task automatic build_steps();
        steps[0]  = '{STEP_WR, REG_VRAM_ADDR, 16'h0040, 16'h0000};
        steps[1]  = '{STEP_WR, REG_VRAM_DATA, 16'h1234, 16'h0000};
        steps[2]  = '{STEP_WR, REG_VRAM_DATA, 16'hABCD, 16'h0000};
        steps[3]  = '{STEP_WR, REG_VRAM_DATA, 16'h5A5A, 16'h0000};
        steps[4]  = '{STEP_RD, REG_VRAM_ADDR, 16'h0000, 16'h0043};   // stepped past 3 writes
        steps[5]  = '{STEP_WR, REG_VRAM_ADDR, 16'h0040, 16'h0000};
        steps[6]  = '{STEP_RD, REG_VRAM_DATA, 16'h0000, 16'h1234};
        steps[7]  = '{STEP_WR, REG_VRAM_ADDR, 16'h0041, 16'h0000};
        steps[8]  = '{STEP_RD, REG_VRAM_DATA, 16'h0000, 16'hABCD};
        steps[9]  = '{STEP_WR, REG_VRAM_ADDR, 16'h0042, 16'h0000};
        steps[10] = '{STEP_RD, REG_VRAM_DATA, 16'h0000, 16'h5A5A};
        steps[11] = '{STEP_WR, REG_XR_ADDR, XR_DISP_START, 16'h0000};
        steps[12] = '{STEP_WR, REG_XR_DATA, 16'(DISP_BASE), 16'h0000};
        steps[13] = '{STEP_WR, REG_XR_DATA, 16'(LINE_WORDS), 16'h0000}; // lands in LINE_LEN
        steps[14] = '{STEP_RD, REG_XR_ADDR, 16'h0000, 16'h0003};
        steps[15] = '{STEP_WR, REG_XR_ADDR, XR_DISP_START, 16'h0000};
        steps[16] = '{STEP_RD, REG_XR_DATA, 16'h0000, 16'(DISP_BASE)};
        steps[17] = '{STEP_WR, REG_XR_ADDR, XR_LINE_LEN, 16'h0000};
        steps[18] = '{STEP_RD, REG_XR_DATA, 16'h0000, 16'(LINE_WORDS)};
    endtask

    task automatic run_steps();
        word_t got;
        for (int i = 0; i < STEP_COUNT; i++) begin
            if (steps[i].kind == STEP_WR) begin
                bus_write(steps[i].reg_num, steps[i].data);
            end else begin
                bus_read(steps[i].reg_num, got);
                check_equal(got, steps[i].expected,
                            $sformatf("step %0d read of register %0d", i, steps[i].reg_num));
            end
        end
    endtask

    // 8 lines of random words from DISP_BASE, then 16 random colours
    task automatic load_display();
        logic [15:0] value;
        bus_write(REG_VRAM_ADDR, 16'(DISP_BASE));
        for (int i = 0; i < LOAD_WORDS; i++) begin
            random_bits(16, value);
            bus_write(REG_VRAM_DATA, value);
        end
        bus_write(REG_XR_ADDR, XR_COLOR_MEM);
        for (int i = 0; i < PAL_SIZE; i++) begin
            random_bits(12, value);
            bus_write(REG_XR_DATA, value);
        end
        load_done = 1'b1;
    endtask

    task automatic test_interrupts();
        word_t got;
        int    seen;
        int    pulse_cycle [3];
        bus_write(REG_INTR, 16'h010F);                 // mask bit 0, drop all pending
        for (int i = 0; i < 3; i++) begin
            seen = intr_count;
            while (intr_count == seen) @(posedge clk);
            pulse_cycle[i] = last_intr_cycle;
            if (i > 0) begin
                check_equal(pulse_cycle[i] - pulse_cycle[i-1], FRAME_CYCLES,
                            "cycles between vblank interrupts");
            end
            bus_read(REG_INTR, got);
            check_equal(got, 16'h0101, "interrupt mask and status after vblank");
            bus_write(REG_INTR, 16'h0101);
            bus_read(REG_INTR, got);
            check_equal(got, 16'h0100, "interrupt status after clear");
        end
        // soft bit 2 stays out of the mask
        bus_write(REG_XR_ADDR, XR_VID_CTRL);
        seen = intr_count;
        bus_write(REG_XR_DATA, 16'h0004);
        bus_read(REG_INTR, got);
        check_equal(got, 16'h0104, "interrupt status after soft bit write");
        check_equal(intr_count, seen, "interrupt pulses from a masked soft bit");
        bus_write(REG_INTR, 16'h0104);
        bus_read(REG_INTR, got);
        check_equal(got, 16'h0100, "interrupt status after soft bit clear");
    endtask

    // outputs are registered on posedge, sampled at negedge
    always @(negedge clk) begin
        if (mon_on) begin
            if (dv_de_o) begin
                if (pix_armed) begin
                    check_equal({red_o, green_o, blue_o}, expected_pixel(px, py),
                                $sformatf("pixel x %0d line %0d", px, py));
                    pix_count++;
                end
                px++;
            end else begin
                check_equal({red_o, green_o, blue_o}, 12'h000, "rgb outside display enable");
                if (de_prev) begin
                    check_equal(px, H_VISIBLE, "display enable cycles per line");
                    px = 0;
                    py++;
                end
            end
            if (hsync_o) begin
                hs_len++;
            end else if (hs_prev) begin
                check_equal(hs_len, H_SYNC, "hsync width");
                hs_len = 0;
            end
            if (vsync_o) begin
                vs_len++;
            end else if (vs_prev) begin
                check_equal(vs_len, V_SYNC * H_TOTAL, "vsync width");
                vs_len = 0;
            end
            if (vsync_o && !vs_prev) begin
                check_equal(py, V_VISIBLE, "display lines per frame");
                py = 0;
                if (pix_armed) begin
                    pix_frames++;
                end else if (load_done) begin
                    pix_armed = 1'b1;                  // next frame is fully loaded
                end
            end
            if (bus_intr_o) begin
                intr_count++;
                last_intr_cycle = cycle_count;
            end
            de_prev = dv_de_o;
            hs_prev = hsync_o;
            vs_prev = vsync_o;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run was still busy after %0d cycles", WATCHDOG_CYCLES);
        $display("Verification failed");
        $finish;
    end

    initial begin
        reset_i       = 1'b1;
        bus_cs_n_i    = 1'b1;
        bus_rd_nwr_i  = 1'b1;
        bus_reg_num_i = 4'h0;
        bus_bytesel_i = 1'b0;
        bus_data_i    = 8'h00;
        build_steps();
        repeat (8) @(posedge clk);
        #DRIVE_DLY;
        reset_i = 1'b0;
        mon_on  = 1'b1;
        run_steps();
        load_display();
        while (pix_frames < 2) @(posedge clk);
        test_interrupts();
        repeat (4) @(posedge clk);
        if (pix_count < 2 * H_VISIBLE * V_VISIBLE) begin
            $display("pixel monitor checked only %0d pixels", pix_count);
            error_count++;
        end
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
hw/vc_pkg.sv
hw/video_ifs.sv
hw/sync_ram.sv
hw/video_timing.sv
hw/video_gen.sv
hw/bus_regs.sv
hw/video_main.sv
testbench/tb_video_main.sv
